// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_core
FLAGS     ?= -j 0
OBJ_DIR   ?= obj_dir
FILELIST  ?= compile.f

SOURCES := $(filter-out +incdir+%,$(shell cat $(FILELIST))) core_settings.svh
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary --timing $(FLAGS) --top-module $(TOP) \
		-f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf $(OBJ_DIR)

// ==== compile.f ====
+incdir+.
isa_pkg.sv
core_pkg.sv
fetch_unit.sv
decode_unit.sv
reg_file.sv
exec_unit.sv
rv_core_top.sv
tb_checker.sv
tb_core.sv

// ==== core_pkg.sv ====
`include "core_settings.svh"

package core_pkg;

    typedef enum logic [1:0] {
        CMD_NOP  = 2'd0,
        CMD_ADD  = 2'd1,
        CMD_HALT = 2'd2
    } exu_cmd_e;

    // what decode hands to execute for one instruction
    typedef struct packed {
        exu_cmd_e                   cmd;
        logic [`XLEN-1:0]           src1;
        logic [`XLEN-1:0]           src2;
        logic [`REG_ADDR_WIDTH-1:0] rd;   // zero when nothing is written
        logic                       wen;
    } dec_op_t;

    typedef struct packed {
        logic [`XLEN-1:0]           pc;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [`XLEN-1:0]           wdata;
    } retire_t;

endpackage

// ==== core_settings.svh ====
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// data path and address width of the core
`define XLEN 32

// 32 architectural registers
`define REG_ADDR_WIDTH 5

// instruction memory size in words, pc wraps modulo this depth
`define IMEM_DEPTH 256

// first instruction fetched after reset
`define RESET_PC 32'h0000_0000

`endif

// ==== decode_unit.sv ====
`timescale 1ns/1ns
`include "core_settings.svh"

module decode_unit (
    input  isa_pkg::inst_t              inst,
    input  logic [`XLEN-1:0]            pc,
    input  logic [`XLEN-1:0]            rdata1,
    input  logic [`XLEN-1:0]            rdata2,
    output logic [`REG_ADDR_WIDTH-1:0]  raddr1,
    output logic [`REG_ADDR_WIDTH-1:0]  raddr2,
    output core_pkg::dec_op_t           op
);

    logic                reg1_ren;
    logic                wreg_en;
    core_pkg::exu_cmd_e  cmd;
    logic [`XLEN-1:0]    src1;
    logic [`XLEN-1:0]    src2;
    logic [`XLEN-1:0]    imm_i;
    logic [`XLEN-1:0]    imm_u;

    assign imm_i = {{(`XLEN-12){inst.i.imm[11]}}, inst.i.imm};
    assign imm_u = {inst.u.imm20, {(`XLEN-20){1'b0}}};

    // unused sources read x0, so the register port returns zero
    assign raddr1 = reg1_ren ? inst.i.rs1 : '0;
    assign raddr2 = '0; // no supported instruction has an rs2

    always_comb begin
        cmd      = core_pkg::CMD_NOP;
        src1     = rdata1;
        src2     = rdata2;
        reg1_ren = 1'b0;
        wreg_en  = 1'b0;
        case (inst.i.opcode)
            isa_pkg::OP_IMM: begin
                if (inst.i.funct3 == isa_pkg::F3_ADD) begin // addi
                    cmd      = core_pkg::CMD_ADD;
                    src1     = imm_i;
                    src2     = rdata1;
                    reg1_ren = 1'b1;
                    wreg_en  = 1'b1;
                end
            end
            isa_pkg::AUIPC: begin // funct3 bits belong to the immediate here
                cmd     = core_pkg::CMD_ADD;
                src1    = pc;
                src2    = imm_u;
                wreg_en = 1'b1;
            end
            isa_pkg::SYSTEM: begin
                if (inst == isa_pkg::EBREAK_WORD) begin
                    cmd = core_pkg::CMD_HALT;
                end
            end
            default: begin
                cmd = core_pkg::CMD_NOP; // retires without a write
            end
        endcase
    end

    assign op = '{
        cmd:  cmd,
        src1: src1,
        src2: src2,
        rd:   wreg_en ? inst.i.rd : '0,
        wen:  wreg_en
    };

endmodule

// ==== exec_unit.sv ====
`timescale 1ns/1ns
`include "core_settings.svh"

module exec_unit (
    input  logic                       clk,
    input  logic                       rst_n,
    input  core_pkg::dec_op_t          op,
    input  logic [`XLEN-1:0]           pc,
    output logic                       wen,
    output logic [`REG_ADDR_WIDTH-1:0] waddr,
    output logic [`XLEN-1:0]           wdata,
    output logic                       retire_valid,
    output core_pkg::retire_t          retire,
    output logic                       halted
);

    logic [`XLEN-1:0] result;
    logic             writes;

    assign result = (op.cmd == core_pkg::CMD_ADD) ? op.src1 + op.src2 : '0;

    // a write to x0 counts as no write in the retire record
    assign writes = op.wen && (op.rd != '0);

    assign wen   = op.wen && !halted;
    assign waddr = op.rd;
    assign wdata = result;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            retire_valid <= 1'b0;
            halted       <= 1'b0;
        end else begin
            retire_valid <= !halted; // ebreak itself still retires
            if (op.cmd == core_pkg::CMD_HALT) begin
                halted <= 1'b1; // only reset clears it
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!halted) begin
            retire <= '{
                pc:    pc,
                rd:    writes ? op.rd : '0,
                wdata: writes ? result : '0
            };
        end
    end

endmodule

// ==== fetch_unit.sv ====
`timescale 1ns/1ns
`include "core_settings.svh"

module fetch_unit #(
    parameter int IDX_WIDTH = $clog2(`IMEM_DEPTH)
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 stall,
    input  logic                 imem_we,
    input  logic [IDX_WIDTH-1:0] imem_addr,
    input  logic [`XLEN-1:0]     imem_wdata,
    output logic [`XLEN-1:0]     pc,
    output isa_pkg::inst_t       inst
);

    logic [`XLEN-1:0]     imem [`IMEM_DEPTH];
    logic [`XLEN-1:0]     pc_next;
    logic [IDX_WIDTH-1:0] fetch_idx;

    // word index, upper pc bits beyond the memory are dropped so the pc wraps
    assign fetch_idx = pc[IDX_WIDTH+1:2];

    assign pc_next = stall ? pc : pc + `XLEN'd4;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= `RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    always_ff @(posedge clk) begin
        if (imem_we) begin
            imem[imem_addr] <= imem_wdata; // loader writes one word per clock
        end
    end

    assign inst = imem[fetch_idx];

endmodule

// ==== isa_pkg.sv ====
package isa_pkg;

    localparam logic [6:0] OP_IMM = 7'b0010011; // addi lives here
    localparam logic [6:0] AUIPC  = 7'b0010111;
    localparam logic [6:0] SYSTEM = 7'b1110011; // ebreak lives here

    localparam logic [2:0] F3_ADD = 3'b000;

    // the one SYSTEM encoding the core understands
    localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    typedef struct packed {
        logic [19:0] imm20; // upper immediate, bits 31:12 of the result
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_type_t;

    // one fetched word, seen either as I-type or as U-type
    typedef union packed {
        i_type_t i;
        u_type_t u;
    } inst_t;

endpackage

// ==== reg_file.sv ====
`timescale 1ns/1ns
`include "core_settings.svh"

module reg_file #(
    parameter int NUM_REGS = 1 << `REG_ADDR_WIDTH
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [`REG_ADDR_WIDTH-1:0] raddr1,
    input  logic [`REG_ADDR_WIDTH-1:0] raddr2,
    output logic [`XLEN-1:0]           rdata1,
    output logic [`XLEN-1:0]           rdata2,
    input  logic                       wen,
    input  logic [`REG_ADDR_WIDTH-1:0] waddr,
    input  logic [`XLEN-1:0]           wdata
);

    // x0 has no storage, entry 0 is never written
    logic [`XLEN-1:0] regs [1:NUM_REGS-1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 1; r < NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else if (wen && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// ==== rv_core_top.sv ====
`timescale 1ns/1ns
`include "core_settings.svh"

module rv_core_top #(
    parameter int IDX_WIDTH = $clog2(`IMEM_DEPTH)
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 imem_we,
    input  logic [IDX_WIDTH-1:0] imem_addr,
    input  logic [`XLEN-1:0]     imem_wdata,
    output logic                 retire_valid,
    output core_pkg::retire_t    retire,
    output logic                 halted
);

    logic [`XLEN-1:0]           pc;
    isa_pkg::inst_t             inst;
    logic [`REG_ADDR_WIDTH-1:0] raddr1;
    logic [`REG_ADDR_WIDTH-1:0] raddr2;
    logic [`XLEN-1:0]           rdata1;
    logic [`XLEN-1:0]           rdata2;
    core_pkg::dec_op_t          op;
    logic                       rf_wen;
    logic [`REG_ADDR_WIDTH-1:0] rf_waddr;
    logic [`XLEN-1:0]           rf_wdata;

    fetch_unit #(
        .IDX_WIDTH(IDX_WIDTH)
    ) fetch0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .stall      (halted), // pc freezes once ebreak has retired
        .imem_we    (imem_we),
        .imem_addr  (imem_addr),
        .imem_wdata (imem_wdata),
        .pc         (pc),
        .inst       (inst)
    );

    decode_unit decode0 (
        .inst   (inst),
        .pc     (pc),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .op     (op)
    );

    reg_file regs0 (
        .clk    (clk),
        .rst_n  (rst_n),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .wen    (rf_wen),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

    exec_unit exec0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .op           (op),
        .pc           (pc),
        .wen          (rf_wen),
        .waddr        (rf_waddr),
        .wdata        (rf_wdata),
        .retire_valid (retire_valid),
        .retire       (retire),
        .halted       (halted)
    );

endmodule

// ==== tb_checker.sv ====
`timescale 1ns/1ns
`include "core_settings.svh"

module tb_checker #(
    parameter int IDX_WIDTH  = $clog2(`IMEM_DEPTH),
    parameter int IDLE_LIMIT = 20
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 imem_we,
    input  logic [IDX_WIDTH-1:0] imem_addr,
    input  logic [`XLEN-1:0]     imem_wdata,
    input  logic                 retire_valid,
    input  core_pkg::retire_t    retire,
    input  logic                 halted,
    output int                   error_count,
    output int                   retire_count
);

    localparam logic [6:0]       OPC_OP_IMM  = 7'b0010011;
    localparam logic [6:0]       OPC_AUIPC   = 7'b0010111;
    localparam logic [`XLEN-1:0] WORD_EBREAK = 32'h0010_0073;

    logic [`XLEN-1:0]  mem_copy [`IMEM_DEPTH];
    logic [`XLEN-1:0]  model_regs [32];
    logic [`XLEN-1:0]  model_pc;
    logic              model_halted;
    core_pkg::retire_t expected;
    int                errors = 0;
    int                retires = 0;
    int                idle_cycles = 0;

    assign error_count  = errors;
    assign retire_count = retires;

    // one instruction of the ISA model, returns the retire record it should produce
    function automatic core_pkg::retire_t step_model();
        core_pkg::retire_t rec;
        logic [`XLEN-1:0]  word;
        logic [`XLEN-1:0]  value;
        logic [4:0]        rd;
        logic              writes;
        word   = mem_copy[model_pc[IDX_WIDTH+1:2]]; // pc wraps over the memory
        rd     = word[11:7];
        value  = '0;
        writes = 1'b0;
        if (word == WORD_EBREAK) begin
            model_halted = 1'b1;
        end else if (word[6:0] == OPC_OP_IMM && word[14:12] == 3'b000) begin
            value  = model_regs[word[19:15]] + {{(`XLEN-12){word[31]}}, word[31:20]};
            writes = 1'b1;
        end else if (word[6:0] == OPC_AUIPC) begin
            value  = model_pc + {word[31:12], 12'b0};
            writes = 1'b1;
        end
        rec.pc    = model_pc;
        rec.rd    = '0;
        rec.wdata = '0;
        if (writes && rd != 5'd0) begin
            model_regs[rd] = value;
            rec.rd         = rd;
            rec.wdata      = value;
        end
        if (!model_halted) begin
            model_pc = model_pc + 32'd4;
        end
        return rec;
    endfunction

    task automatic reset_model();
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        model_pc     = `RESET_PC;
        model_halted = 1'b0;
        idle_cycles  = 0;
    endtask

    task automatic compare_field(input string name, input logic [`XLEN-1:0] exp,
                                 input logic [`XLEN-1:0] act);
        if (act !== exp) begin
            $display("** Error at %0t ns: %s expected %h actual %h", $time, name, exp, act);
            errors++;
        end
    endtask

    // outputs change on the rising edge, so everything is sampled on the falling one
    always @(negedge clk) begin
        if (imem_we) begin
            mem_copy[imem_addr] = imem_wdata;
        end
        if (!rst_n) begin
            reset_model();
        end else begin
            if (retire_valid) begin
                idle_cycles = 0;
                if (model_halted) begin
                    $display("retire seen at %0t ns for pc %h after the core had halted",
                             $time, retire.pc);
                    errors++;
                end else begin
                    expected = step_model();
                    retires++;
                    compare_field("retire.pc", expected.pc, retire.pc);
                    compare_field("retire.rd", {27'b0, expected.rd}, {27'b0, retire.rd});
                    compare_field("retire.wdata", expected.wdata, retire.wdata);
                end
            end else if (!model_halted) begin
                idle_cycles++;
                if (idle_cycles == IDLE_LIMIT) begin
                    $display("no retire arrived within %0d cycles, model pc is %h",
                             IDLE_LIMIT, model_pc);
                    errors++;
                end
            end
            if (halted !== model_halted) begin
                $display("** Error at %0t ns: halted expected %0b actual %0b",
                         $time, model_halted, halted);
                errors++;
            end
        end
    end

endmodule

// ==== tb_core.sv ====
`timescale 1ns/1ns
`include "core_settings.svh"

module tb_core;

    localparam int              IDX_WIDTH    = $clog2(`IMEM_DEPTH);
    localparam int              RESET_CYCLES = 4;
    localparam int              RANDOM_LEN   = 200;
    localparam logic [`XLEN-1:0] EBREAK_INSN = 32'h0010_0073;

    logic                 clk;
    logic                 rst_n;
    logic                 imem_we;
    logic [IDX_WIDTH-1:0] imem_addr;
    logic [`XLEN-1:0]     imem_wdata;
    logic                 retire_valid;
    core_pkg::retire_t    retire;
    logic                 halted;
    int                   error_count;
    int                   retire_count;

    logic [`XLEN-1:0] prog [$];
    int               seed;
    int               tests_passed;
    int               tests_failed;
    int               local_errors;
    int               base_errors;
    int               base_retires;
    bit               aborted;

    rv_core_top #(
        .IDX_WIDTH(IDX_WIDTH)
    ) dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .imem_we      (imem_we),
        .imem_addr    (imem_addr),
        .imem_wdata   (imem_wdata),
        .retire_valid (retire_valid),
        .retire       (retire),
        .halted       (halted)
    );

    tb_checker #(
        .IDX_WIDTH(IDX_WIDTH)
    ) checker0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .imem_we      (imem_we),
        .imem_addr    (imem_addr),
        .imem_wdata   (imem_wdata),
        .retire_valid (retire_valid),
        .retire       (retire),
        .halted       (halted),
        .error_count  (error_count),
        .retire_count (retire_count)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    function automatic logic [`XLEN-1:0] addi_word(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
    endfunction

    function automatic logic [`XLEN-1:0] auipc_word(input int rd, input int imm20);
        return {imm20[19:0], rd[4:0], 7'b0010111};
    endfunction

    task automatic begin_test();
        base_errors  = error_count;
        local_errors = 0;
        prog.delete();
    endtask

    // reset stays low while the program is written, at least RESET_CYCLES clocks
    task automatic load_and_start();
        int n;
        n = (prog.size() > RESET_CYCLES) ? prog.size() : RESET_CYCLES;
        @(posedge clk);
        #1;
        rst_n = 1'b0;
        for (int c = 0; c < n; c++) begin
            imem_we = (c < prog.size());
            if (c < prog.size()) begin
                imem_addr  = c[IDX_WIDTH-1:0];
                imem_wdata = prog[c];
            end
            @(posedge clk);
            #1;
        end
        imem_we      = 1'b0;
        base_retires = retire_count;
        rst_n        = 1'b1;
    endtask

    task automatic wait_for_halt(input int limit);
        int cycles;
        cycles = 0;
        while (!halted && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (!halted) begin
            $display("timeout: the core did not halt within %0d cycles", limit);
            aborted = 1'b1;
        end
    endtask

    task automatic wait_for_retires(input int count, input int limit);
        int cycles;
        cycles = 0;
        while (retire_count - base_retires < count && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        if (retire_count - base_retires < count) begin
            $display("timeout: %0d retires did not arrive within %0d cycles", count, limit);
            aborted = 1'b1;
        end
    endtask

    task automatic finish_test(input string name, input int expected_retires);
        int errs;
        int retired;
        @(posedge clk); // checker counts settle on the falling edge
        retired = retire_count - base_retires;
        if (retired != expected_retires) begin
            $display("** Error at %0t ns: retire count expected %0d actual %0d",
                     $time, expected_retires, retired);
            local_errors++;
        end
        errs = error_count - base_errors + local_errors;
        if (errs == 0 && !aborted) begin
            tests_passed++;
            $display("test %s: passed with %0d retires", name, retired);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errs);
        end
    endtask

    task automatic run_program(input string name);
        load_and_start();
        wait_for_halt(prog.size() + 50);
        finish_test(name, prog.size());
    endtask

    task automatic addi_chain();
        begin_test();
        prog.push_back(addi_word(1, 0, 5));
        prog.push_back(addi_word(2, 1, -3));
        prog.push_back(addi_word(3, 2, 2047));
        prog.push_back(addi_word(4, 3, -2048));
        prog.push_back(addi_word(0, 4, 100)); // write to x0 is dropped
        prog.push_back(addi_word(5, 0, -1));
        prog.push_back(addi_word(6, 5, -2047));
        prog.push_back(addi_word(1, 1, 1));
        prog.push_back(EBREAK_INSN);
        run_program("addi");
    endtask

    task automatic auipc_sweep();
        begin_test();
        prog.push_back(auipc_word(1, 'hfffff));
        prog.push_back(addi_word(0, 0, 0));
        prog.push_back(auipc_word(2, 'h80000));
        prog.push_back(auipc_word(3, 'h12345));
        prog.push_back(auipc_word(0, 'habcde));
        prog.push_back(addi_word(0, 0, 0));
        prog.push_back(auipc_word(4, 'h7ffff));
        prog.push_back(addi_word(5, 3, 1));
        prog.push_back(EBREAK_INSN);
        run_program("auipc");
    endtask

    task automatic unknown_words();
        begin_test();
        prog.push_back(addi_word(1, 0, 100));
        prog.push_back(addi_word(2, 0, -50));
        prog.push_back(32'h0000_0000);
        prog.push_back(32'hffff_ffff);
        prog.push_back({12'd5, 5'd1, 3'b010, 5'd1, 7'b0010011}); // slti, not addi
        prog.push_back({20'h12345, 5'd2, 7'b0110111});           // lui
        prog.push_back(32'h0000_0073);                           // ecall
        prog.push_back(addi_word(3, 1, 0));
        prog.push_back(addi_word(4, 2, 0));
        prog.push_back(EBREAK_INSN);
        run_program("unknown encodings");
    endtask

    task automatic ebreak_stop();
        begin_test();
        prog.push_back(addi_word(1, 0, 1));
        prog.push_back(EBREAK_INSN);
        prog.push_back(addi_word(2, 0, 2)); // must never run
        load_and_start();
        wait_for_halt(50);
        repeat (30) begin
            @(negedge clk);
            if (halted !== 1'b1) begin
                $display("** Error at %0t ns: halted expected 1 actual %b", $time, halted);
                local_errors++;
            end
            if (retire_valid !== 1'b0) begin
                $display("** Error at %0t ns: retire_valid expected 0 actual %b",
                         $time, retire_valid);
                local_errors++;
            end
        end
        finish_test("ebreak", 2);
    endtask

    task automatic reset_restart();
        begin_test();
        repeat (30) prog.push_back(addi_word(1, 1, 1));
        prog.push_back(EBREAK_INSN);
        load_and_start();
        wait_for_retires(10, 40);
        prog.delete();
        prog.push_back(addi_word(2, 1, 0)); // x1 reads zero after reset
        prog.push_back(addi_word(3, 2, -7));
        prog.push_back(auipc_word(4, 1));
        prog.push_back(EBREAK_INSN);
        run_program("reset mid-run");
    endtask

    task automatic random_mix();
        int               r;
        int               kind;
        logic [`XLEN-1:0] w;
        begin_test();
        for (int n = 0; n < RANDOM_LEN; n++) begin
            r    = $random(seed);
            kind = ((r >> 4) & 255) % 3;
            if (kind == 0) begin
                prog.push_back(addi_word((r >> 12) & 31, (r >> 17) & 31, $random(seed)));
            end else if (kind == 1) begin
                prog.push_back(auipc_word((r >> 12) & 31, $random(seed)));
            end else begin
                w = $random(seed);
                case (r & 3)
                    0:       w[6:0] = 7'b0110011;
                    1:       w[6:0] = 7'b0000011;
                    2:       w[6:0] = 7'b1100011;
                    default: w[6:0] = 7'b0110111;
                endcase
                prog.push_back(w);
            end
        end
        prog.push_back(EBREAK_INSN);
        run_program("random mix");
    endtask

    initial begin
        rst_n        = 1'b0;
        imem_we      = 1'b0;
        imem_addr    = '0;
        imem_wdata   = '0;
        seed         = 32'hde71_8e18;
        tests_passed = 0;
        tests_failed = 0;
        local_errors = 0;
        base_errors  = 0;
        base_retires = 0;
        aborted      = 1'b0;
        addi_chain();
        if (!aborted) auipc_sweep();
        if (!aborted) unknown_words();
        if (!aborted) ebreak_stop();
        if (!aborted) reset_restart();
        if (!aborted) random_mix();
        $display("tests: %0d passed, %0d failed, %0d checker errors",
                 tests_passed, tests_failed, error_count);
        if (tests_failed == 0 && error_count == 0 && !aborted) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
